//--- all.f
+incdir+design
design/cache_types_pkg.sv
design/mem_types_pkg.sv
design/dcache_control.sv
design/dcache_datapath.sv
design/icache.sv
design/pmem_arbiter.sv
design/mem_subsystem.sv
sim/mem_subsystem_checker.sv
sim/tb_mem_subsystem.sv

//--- Makefile
TOP := tb_mem_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | awk '{ print } $$0 == "SIMULATION PASSED" { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- sim/tb_mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module tb_mem_subsystem;

  import cache_types_pkg::*;
  import mem_types_pkg::*;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 16;
  localparam int          RANDOM_OPS   = 300;
  // directed accesses plus two per random step at most
  localparam int          ACCESS_COUNT = 11 + 2 * RANDOM_OPS;
  localparam logic [31:0] SEED         = 32'h9760_b360;

  logic      clk;
  logic      rst;
  cpu_req_t  ireq;
  cpu_rsp_t  irsp;
  cpu_req_t  dreq;
  cpu_rsp_t  drsp;
  pmem_req_t pmem_req;
  pmem_rsp_t pmem_rsp;

  // shadow holds the cpu view and mem_words the real memory
  logic [31:0] shadow_words [bit [31:0]];
  logic [31:0] mem_words    [bit [31:0]];
  string       d_name;
  string       i_name;
  logic [31:0] d_expect;
  logic [31:0] i_expect;
  int          writebacks = 0;

  mem_subsystem u_dut (
    .clk      (clk),
    .rst      (rst),
    .ireq     (ireq),
    .irsp     (irsp),
    .dreq     (dreq),
    .drsp     (drsp),
    .pmem_req (pmem_req),
    .pmem_rsp (pmem_rsp)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // untouched memory depends on every address bit
  function automatic logic [31:0] fill_pattern(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] ref_access(input logic write, input logic [31:0] addr,
                                            input logic [31:0] wdata, input logic [3:0] mask);
    logic [31:0] a;
    logic [31:0] w;
    a = {addr[31:2], 2'b00};
    w = shadow_words.exists(a) ? shadow_words[a] : fill_pattern(a);
    if (write)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (mask[b])
          w[b*8 +: 8] = wdata[b*8 +: 8];
      end
      shadow_words[a] = w;
    end
    return w;
  endfunction

  function automatic logic [`LINE_BITS-1:0] shadow_line(input logic [31:0] addr);
    logic [`LINE_BITS-1:0] line;
    logic [31:0]           a;
    for (int i = 0; i < 8; i++)
    begin
      a = addr + i * 4;
      line[i*32 +: 32] = shadow_words.exists(a) ? shadow_words[a] : fill_pattern(a);
    end
    return line;
  endfunction

  function automatic logic [`LINE_BITS-1:0] load_line(input logic [31:0] addr);
    logic [`LINE_BITS-1:0] line;
    logic [31:0]           a;
    for (int i = 0; i < 8; i++)
    begin
      a = addr + i * 4;
      line[i*32 +: 32] = mem_words.exists(a) ? mem_words[a] : fill_pattern(a);
    end
    return line;
  endfunction

  function automatic void store_line(input logic [31:0] addr,
                                     input logic [`LINE_BITS-1:0] line);
    for (int i = 0; i < 8; i++)
      mem_words[addr + i * 4] = line[i*32 +: 32];
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input cpu_rsp_t actual);
    if (actual.rdata !== expected)
      stop_on_error($sformatf("mismatch %s expected %h actual %h",
                              name, expected, actual.rdata));
  endtask

  task automatic check_line(input string name, input logic [`LINE_BITS-1:0] expected,
                            input pmem_req_t actual);
    if (actual.wdata !== expected)
      stop_on_error($sformatf("mismatch %s expected %h actual %h",
                              name, expected, actual.wdata));
  endtask

  task automatic check_latency(input string name, input int cycles);
    if (cycles != 2)
      stop_on_error($sformatf("mismatch %s expected 2 actual %0d", name, cycles));
  endtask

  task automatic data_access(input string name, input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] mask,
                             output int cycles);
    cpu_req_t req;
    @(posedge clk);
    #2;
    req.read  = ~write;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    req.mask  = mask;
    d_name    = name;
    d_expect  = ref_access(write, addr, wdata, mask);
    dreq      = req;
    cycles    = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (!drsp.resp);
    #2;
    dreq = '0;
  endtask

  // some calls set the write field, which the icache ignores
  task automatic inst_access(input string name, input logic write_field,
                             input logic [31:0] addr, output int cycles);
    cpu_req_t req;
    @(posedge clk);
    #2;
    req.read  = 1'b1;
    req.write = write_field;
    req.addr  = addr;
    req.wdata = 32'hffff_ffff;
    req.mask  = 4'hf;
    i_name    = name;
    i_expect  = ref_access(1'b0, addr, 32'h0, 4'h0);
    ireq      = req;
    cycles    = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (!irsp.resp);
    #2;
    ireq = '0;
  endtask

  initial
  begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory answers 1 to 4 cycles after it sees a request
  initial
  begin : memory_model
    logic [31:0] mem_rng;
    mem_rng  = SEED;
    pmem_rsp = '0;
    forever
    begin
      @(posedge clk);
      if (!rst && (pmem_req.read || pmem_req.write))
      begin
        mem_rng = xorshift32(mem_rng);
        repeat (mem_rng[1:0]) @(posedge clk);
        #2;
        if (pmem_req.write)
          store_line(pmem_req.addr, pmem_req.wdata);
        else
          pmem_rsp.rdata = load_line(pmem_req.addr);
        pmem_rsp.resp = 1'b1;
        @(posedge clk);
        #2;
        pmem_rsp = '0;
      end
    end
  end

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (drsp.resp && dreq.read)
        check_word(d_name, d_expect, drsp);
      if (irsp.resp)
        check_word(i_name, i_expect, irsp);
      if (pmem_req.write && pmem_rsp.resp)
      begin
        check_line("write-back line", shadow_line(pmem_req.addr), pmem_req);
        writebacks++;
      end
      if (u_dut.u_checker.fail_count != 0)
        stop_on_error("an assertion in the bound checker failed");
    end
  end

  initial
  begin : watchdog
    #(CLK_PERIOD * (RESET_CYCLES + 8 + 200 * ACCESS_COUNT));
    stop_on_error("watchdog expired, an access never completed");
  end

  initial
  begin : stimulus
    int          cycles;
    int          icycles;
    int          wb_before;
    logic [31:0] stim_rng;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] iaddr;
    rst  = 1'b1;
    ireq = '0;
    dreq = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    repeat (4)
    begin
      @(posedge clk);
      if (irsp.resp || drsp.resp || pmem_req.read || pmem_req.write)
        stop_on_error("response or memory strobe active after reset with no request");
    end

    data_access("read miss", 1'b0, 32'h0000_1044, 32'h0, 4'h0, cycles);
    data_access("read hit", 1'b0, 32'h0000_1048, 32'h0, 4'h0, cycles);
    check_latency("data hit latency", cycles);

    data_access("partial write", 1'b1, 32'h0000_1050, 32'hdead_beef, 4'b0101, cycles);
    data_access("merged read", 1'b0, 32'h0000_1050, 32'h0, 4'h0, cycles);

    // three tags into set 6 with the first one dirty
    wb_before = writebacks;
    data_access("victim write", 1'b1, 32'h0000_30c4, 32'h1234_5678, 4'hf, cycles);
    data_access("second tag read", 1'b0, 32'h0000_31c8, 32'h0, 4'h0, cycles);
    data_access("third tag read", 1'b0, 32'h0000_32cc, 32'h0, 4'h0, cycles);
    if (writebacks == wb_before)
      stop_on_error("no write-back happened when a dirty line was evicted");
    data_access("reread after eviction", 1'b0, 32'h0000_30c4, 32'h0, 4'h0, cycles);

    fork
      data_access("parallel data read", 1'b0, 32'h0000_1064, 32'h0, 4'h0, cycles);
      inst_access("parallel instruction read", 1'b1, 32'h0008_0124, icycles);
    join
    inst_access("instruction reread", 1'b0, 32'h0008_0124, icycles);
    check_latency("instruction hit latency", icycles);

    // data at 0x0002xxxx and instructions at 0x0008xxxx over sets 0 to 3
    stim_rng = SEED;
    repeat (RANDOM_OPS)
    begin
      stim_rng = xorshift32(stim_rng);
      r        = stim_rng;
      addr     = {16'h0002, 6'h0, r[9:8], 1'b0, r[11:10], r[14:12], 2'b00};
      iaddr    = {16'h0008, 6'h0, r[17:16], 1'b0, r[19:18], r[22:20], 2'b00};
      case (r[1:0])
        2'd0:
          data_access("random read", 1'b0, addr, 32'h0, 4'h0, cycles);
        2'd1:
          data_access("random write", 1'b1, addr, xorshift32(r), r[7:4], cycles);
        2'd2:
          inst_access("random instruction read", 1'b0, iaddr, icycles);
        default:
          fork
            data_access("random mixed data", r[2], addr, ~r, r[7:4], cycles);
            inst_access("random mixed instruction", 1'b0, iaddr, icycles);
          join
      endcase
    end

    repeat (4) @(posedge clk);
    if (u_dut.u_checker.fail_count == 0)
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
      stop_on_error("bound checker reported an assertion failure");
  end

endmodule

`default_nettype wire

//--- sim/mem_subsystem_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem_checker (
  input logic                      clk,
  input logic                      rst,
  input cache_types_pkg::cpu_req_t ireq,
  input cache_types_pkg::cpu_req_t dreq,
  input cache_types_pkg::cpu_rsp_t irsp,
  input cache_types_pkg::cpu_rsp_t drsp,
  input mem_types_pkg::pmem_req_t  pmem_req,
  input mem_types_pkg::pmem_req_t  i_mem_req,
  input mem_types_pkg::pmem_req_t  d_mem_req,
  input mem_types_pkg::pmem_rsp_t  pmem_rsp
);

  int unsigned fail_count = 0;
  logic        mem_busy;
  logic [1:0]  source;

  assign mem_busy = pmem_req.read | pmem_req.write;
  // which cache the port is forwarding
  assign source = {mem_busy && (pmem_req == d_mem_req),
                   mem_busy && (pmem_req == i_mem_req)};

  read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(pmem_req.read && pmem_req.write))
  else
  begin
    fail_count++;
    $error("memory port drives read and write together");
  end

  grant_held: assert property (@(posedge clk) disable iff (rst)
    mem_busy && !pmem_rsp.resp |=> $stable(source))
  else
  begin
    fail_count++;
    $error("granted source changed while a memory request waited");
  end

  // a pulse answers only a request already sampled at the previous edge
  resp_needs_request: assert property (@(posedge clk) disable iff (rst)
    (!irsp.resp || $past(ireq.read)) &&
    (!drsp.resp || $past(dreq.read || dreq.write)))
  else
  begin
    fail_count++;
    $error("cpu response pulse without a matching request");
  end

endmodule

bind mem_subsystem mem_subsystem_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .ireq      (ireq),
  .dreq      (dreq),
  .irsp      (irsp),
  .drsp      (drsp),
  .pmem_req  (pmem_req),
  .i_mem_req (i_mem_req),
  .d_mem_req (d_mem_req),
  .pmem_rsp  (pmem_rsp)
);

`default_nettype wire

//--- design/mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem (
  input  logic                      clk,
  input  logic                      rst,
  input  cache_types_pkg::cpu_req_t ireq,
  output cache_types_pkg::cpu_rsp_t irsp,
  input  cache_types_pkg::cpu_req_t dreq,
  output cache_types_pkg::cpu_rsp_t drsp,
  output mem_types_pkg::pmem_req_t  pmem_req,
  input  mem_types_pkg::pmem_rsp_t  pmem_rsp
);

  import cache_types_pkg::*;
  import mem_types_pkg::*;

  dcache_ctrl_t   d_ctrl;
  dcache_status_t d_status;
  pmem_req_t      i_mem_req;
  pmem_req_t      d_mem_req;
  pmem_rsp_t      i_mem_rsp;
  pmem_rsp_t      d_mem_rsp;

  icache u_icache (
    .clk     (clk),
    .rst     (rst),
    .req     (ireq),
    .rsp     (irsp),
    .mem_req (i_mem_req),
    .mem_rsp (i_mem_rsp)
  );

  dcache_control u_dcache_control (
    .clk       (clk),
    .rst       (rst),
    .req       (dreq),
    .status    (d_status),
    .ctrl      (d_ctrl),
    .resp      (drsp.resp),
    .mem_read  (d_mem_req.read),
    .mem_write (d_mem_req.write),
    .mem_resp  (d_mem_rsp.resp)
  );

  dcache_datapath u_dcache_datapath (
    .clk       (clk),
    .rst       (rst),
    .req       (dreq),
    .ctrl      (d_ctrl),
    .status    (d_status),
    .rdata     (drsp.rdata),
    .mem_addr  (d_mem_req.addr),
    .mem_wdata (d_mem_req.wdata),
    .mem_rdata (d_mem_rsp.rdata)
  );

  pmem_arbiter u_pmem_arbiter (
    .clk     (clk),
    .rst     (rst),
    .ireq    (i_mem_req),
    .dreq    (d_mem_req),
    .irsp    (i_mem_rsp),
    .drsp    (d_mem_rsp),
    .mem_req (pmem_req),
    .mem_rsp (pmem_rsp)
  );

endmodule

`default_nettype wire

//--- design/pmem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module pmem_arbiter (
  input  logic                     clk,
  input  logic                     rst,
  input  mem_types_pkg::pmem_req_t ireq,
  input  mem_types_pkg::pmem_req_t dreq,
  output mem_types_pkg::pmem_rsp_t irsp,
  output mem_types_pkg::pmem_rsp_t drsp,
  output mem_types_pkg::pmem_req_t mem_req,
  input  mem_types_pkg::pmem_rsp_t mem_rsp
);

  import mem_types_pkg::*;

  arb_state_e state;
  arb_state_e state_next;
  logic       i_active;
  logic       d_active;

  assign i_active = ireq.read | ireq.write;
  assign d_active = dreq.read | dreq.write;

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= state_next;
  end

  // data cache wins a tie
  always_comb
  begin
    state_next = state;
    case (state)
      ARB_IDLE:
      begin
        if (d_active)
          state_next = ARB_DCACHE;
        else if (i_active)
          state_next = ARB_ICACHE;
      end
      ARB_ICACHE, ARB_DCACHE:
      begin
        if (mem_rsp.resp)
          state_next = ARB_IDLE;
      end
      default:
        state_next = ARB_IDLE;
    endcase
  end

  always_comb
  begin
    mem_req = '0;
    irsp    = '0;
    drsp    = '0;
    case (state)
      ARB_ICACHE:
      begin
        mem_req = ireq;
        irsp    = mem_rsp;
      end
      ARB_DCACHE:
      begin
        mem_req = dreq;
        drsp    = mem_rsp;
      end
      default:
        ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module icache (
  input  logic                      clk,
  input  logic                      rst,
  input  cache_types_pkg::cpu_req_t req,
  output cache_types_pkg::cpu_rsp_t rsp,
  output mem_types_pkg::pmem_req_t  mem_req,
  input  mem_types_pkg::pmem_rsp_t  mem_rsp
);

  import cache_types_pkg::*;

  tag_t                    tags  [`SETS];
  logic [`LINE_BITS-1:0]   lines [`SETS];
  logic [`SETS-1:0]        valid;
  dcache_state_e           state;
  dcache_state_e           state_next;
  tag_t                    tag;
  index_t                  idx;
  logic [`OFFSET_BITS-3:0] word;
  logic                    hit;
  logic                    fill_done;

  assign tag       = req.addr[31 -: `TAG_BITS];
  assign idx       = req.addr[`OFFSET_BITS +: `INDEX_BITS];
  assign word      = req.addr[`OFFSET_BITS-1:2];
  assign hit       = valid[idx] && (tags[idx] == tag);
  assign fill_done = (state == FILL) && mem_rsp.resp;

  // the write field never starts a lookup
  assign rsp.resp  = (state == CHECK) && req.read && hit;
  assign rsp.rdata = lines[idx][word*32 +: 32];

  assign mem_req.read  = (state == FILL);
  assign mem_req.write = 1'b0;
  assign mem_req.addr  = {tag, idx, {`OFFSET_BITS{1'b0}}};
  assign mem_req.wdata = '0;

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (req.read)
          state_next = CHECK;
      end
      CHECK:
      begin
        if (!req.read)
          state_next = IDLE;
        else if (!hit)
          state_next = FILL;
      end
      FILL:
      begin
        if (mem_rsp.resp)
          state_next = CHECK;
      end
      default:
        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
      valid <= '0;
    end
    else
    begin
      state <= state_next;
      if (fill_done)
        valid[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_done)
    begin
      tags[idx]  <= tag;
      lines[idx] <= mem_rsp.rdata;
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_datapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module dcache_datapath (
  input  logic                            clk,
  input  logic                            rst,
  input  cache_types_pkg::cpu_req_t       req,
  input  cache_types_pkg::dcache_ctrl_t   ctrl,
  output cache_types_pkg::dcache_status_t status,
  output logic [31:0]                     rdata,
  output logic [31:0]                     mem_addr,
  output logic [`LINE_BITS-1:0]           mem_wdata,
  input  logic [`LINE_BITS-1:0]           mem_rdata
);

  import cache_types_pkg::*;

  tag_t                  tags  [2][`SETS];
  logic [`LINE_BITS-1:0] lines [2][`SETS];
  logic [`SETS-1:0]      valid [2];
  logic [`SETS-1:0]      dirty [2];
  logic [`SETS-1:0]      lru;

  tag_t                   tag;
  index_t                 idx;
  logic [`OFFSET_BITS-3:0] word;
  logic [1:0]             way_match;
  logic                   victim;
  logic [`LINE_BITS-1:0]  hit_line;
  logic [`LINE_BITS-1:0]  merged_line;

  assign tag  = req.addr[31 -: `TAG_BITS];
  assign idx  = req.addr[`OFFSET_BITS +: `INDEX_BITS];
  assign word = req.addr[`OFFSET_BITS-1:2];

  assign way_match[0] = valid[0][idx] && (tags[0][idx] == tag);
  assign way_match[1] = valid[1][idx] && (tags[1][idx] == tag);

  assign status.hit     = |way_match;
  assign status.hit_way = way_match[1];
  assign status.dirty   = {dirty[1][idx], dirty[0][idx]};
  assign status.lru     = lru[idx];

  assign victim   = lru[idx];
  assign hit_line = lines[status.hit_way][idx];
  assign rdata    = hit_line[word*32 +: 32];

  // byte merge of the cpu write into the hit line
  always_comb
  begin
    merged_line = hit_line;
    for (int b = 0; b < 4; b++)
    begin
      if (req.mask[b])
        merged_line[word*32 + b*8 +: 8] = req.wdata[b*8 +: 8];
    end
  end

  // victim still dirty means write-back pending, else fill from request tag
  assign mem_addr  = dirty[victim][idx] ?
                     {tags[victim][idx], idx, {`OFFSET_BITS{1'b0}}} :
                     {tag, idx, {`OFFSET_BITS{1'b0}}};
  assign mem_wdata = lines[victim][idx];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid[0] <= '0;
      valid[1] <= '0;
      dirty[0] <= '0;
      dirty[1] <= '0;
      lru      <= '0;
    end
    else
    begin
      for (int w = 0; w < 2; w++)
      begin
        if (ctrl.ld_valid[w])
          valid[w][idx] <= 1'b1;
        if (ctrl.ld_dirty[w])
          dirty[w][idx] <= ctrl.dirty_val;
      end
      if (ctrl.ld_lru)
        lru[idx] <= ctrl.lru_val;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int w = 0; w < 2; w++)
    begin
      if (ctrl.ld_tag[w])
        tags[w][idx] <= tag;
    end
    case (ctrl.data_sel)
      DATA_CPU_WRITE:
        lines[status.hit_way][idx] <= merged_line;
      DATA_FILL:
        lines[victim][idx] <= mem_rdata;
      default:
        ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/dcache_control.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_control (
  input  logic                            clk,
  input  logic                            rst,
  input  cache_types_pkg::cpu_req_t       req,
  input  cache_types_pkg::dcache_status_t status,
  output cache_types_pkg::dcache_ctrl_t   ctrl,
  output logic                            resp,
  output logic                            mem_read,
  output logic                            mem_write,
  input  logic                            mem_resp
);

  import cache_types_pkg::*;

  dcache_state_e state;
  dcache_state_e state_next;
  logic          active;
  logic          victim;

  assign active = req.read | req.write;
  // the lru way is the one to replace
  assign victim = status.lru;

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (active)
          state_next = CHECK;
      end
      CHECK:
      begin
        if (!active)
          state_next = IDLE;
        else if (!status.hit)
          state_next = BUFFER;
      end
      BUFFER:
      begin
        if (status.dirty[victim])
          state_next = WRITE_BACK;
        else
          state_next = FILL;
      end
      WRITE_BACK:
      begin
        if (mem_resp)
          state_next = FILL;
      end
      FILL:
      begin
        // back to check, which then hits
        if (mem_resp)
          state_next = CHECK;
      end
      default:
        state_next = IDLE;
    endcase
  end

  always_comb
  begin
    ctrl          = '0;
    ctrl.data_sel = DATA_HOLD;
    resp          = 1'b0;
    mem_read      = 1'b0;
    mem_write     = 1'b0;
    case (state)
      CHECK:
      begin
        if (active && status.hit)
        begin
          resp         = 1'b1;
          ctrl.ld_lru  = 1'b1;
          ctrl.lru_val = ~status.hit_way;
          if (req.write)
          begin
            ctrl.ld_dirty[status.hit_way] = 1'b1;
            ctrl.dirty_val                = 1'b1;
            ctrl.data_sel                 = DATA_CPU_WRITE;
          end
        end
      end
      WRITE_BACK:
      begin
        mem_write = 1'b1;
        if (mem_resp)
        begin
          ctrl.ld_dirty[victim] = 1'b1;
          ctrl.dirty_val        = 1'b0;
        end
      end
      FILL:
      begin
        mem_read = 1'b1;
        if (mem_resp)
        begin
          ctrl.ld_tag[victim]   = 1'b1;
          ctrl.ld_valid[victim] = 1'b1;
          ctrl.ld_dirty[victim] = 1'b1;
          ctrl.dirty_val        = 1'b0;
          ctrl.data_sel         = DATA_FILL;
        end
      end
      default:
        ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/mem_types_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package mem_types_pkg;

  // one whole line per beat at a line-aligned address
  typedef struct packed {
    logic                  read;
    logic                  write;
    logic [31:0]           addr;
    logic [`LINE_BITS-1:0] wdata;
  } pmem_req_t;

  typedef struct packed {
    logic                  resp;
    logic [`LINE_BITS-1:0] rdata;
  } pmem_rsp_t;

  typedef enum logic [1:0] {ARB_IDLE, ARB_ICACHE, ARB_DCACHE} arb_state_e;

endpackage

`default_nettype wire

//--- design/cache_types_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_types_pkg;

  typedef logic [`TAG_BITS-1:0] tag_t;
  typedef logic [`INDEX_BITS-1:0] index_t;

  typedef struct packed {
    logic        read;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  mask;
  } cpu_req_t;

  typedef struct packed {
    logic        resp;
    logic [31:0] rdata;
  } cpu_rsp_t;

  typedef enum logic [2:0] {IDLE, CHECK, BUFFER, WRITE_BACK, FILL} dcache_state_e;

  // what the line arrays load this cycle
  typedef enum logic [1:0] {DATA_HOLD, DATA_CPU_WRITE, DATA_FILL} data_sel_e;

  typedef struct packed {
    logic [1:0] ld_tag;
    logic [1:0] ld_valid;
    logic [1:0] ld_dirty;
    logic       dirty_val;
    logic       ld_lru;
    logic       lru_val;
    data_sel_e  data_sel;
  } dcache_ctrl_t;

  typedef struct packed {
    logic       hit;
    logic       hit_way;
    logic [1:0] dirty;
    logic       lru;
  } dcache_status_t;

endpackage

`default_nettype wire

//--- design/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address split as tag | index | offset
`define OFFSET_BITS 5
`define INDEX_BITS 3
`define TAG_BITS 24

// one set per index value
`define SETS 8

// eight 32-bit words
`define LINE_BITS 256

`endif
